// File: design/cart_rom_arbiter.sv
module cart_rom_arbiter (
  input  logic                    CLK2,
  input  logic                    SNES_reset_strobe,
  input  logic                    snes_cpu_clk,
  input  logic                    snes_rom_hit,
  // context writer
  input  logic                    ctx_wrq,
  input  rom_port_pkg::wide_req_t ctx_req,
  output logic                    ctx_ready,
  // mcu
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  rom_port_pkg::mcu_req_t  mcu_req,
  output logic                    mcu_ready,
  output logic [7:0]              mcu_rdata,
  // dma engine
  input  logic                    dma_rrq,
  input  logic                    dma_wrq,
  input  rom_port_pkg::wide_req_t dma_req,
  output logic                    dma_ready,
  output logic [15:0]             dma_rdata,
  // psram port
  output logic [22:0]             rom_addr,
  output logic [15:0]             rom_wdata,
  input  logic [15:0]             rom_rdata,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n
);
  import rom_port_pkg::*;

  logic      free_slot;
  logic      ctx_pend_wr;
  logic      mcu_pend_rd;
  logic      mcu_pend_wr;
  logic      dma_pend_rd;
  logic      dma_pend_wr;
  logic      ctx_done;
  logic      mcu_done;
  logic      dma_done;
  logic      writing;
  logic      rd_addr0;
  req_kind_t grant;
  wide_req_t ctx_held;
  mcu_req_t  mcu_held;
  wide_req_t dma_held;

  snes_cycle_tracker u_tracker (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .snes_cpu_clk      (snes_cpu_clk),
    .snes_rom_hit      (snes_rom_hit),
    .cycle_start       (),
    .free_slot         (free_slot)
  );

  ////////////////////////////////////////
  // request slots
  ////////////////////////////////////////

  rom_request_slot #(.payload_t(wide_req_t)) u_ctx_slot (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .rrq               (1'b0),  // write only
    .wrq               (ctx_wrq),
    .req_in            (ctx_req),
    .done              (ctx_done),
    .ready             (ctx_ready),
    .pend_rd           (),
    .pend_wr           (ctx_pend_wr),
    .req_held          (ctx_held)
  );

  rom_request_slot #(.payload_t(mcu_req_t)) u_mcu_slot (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .rrq               (mcu_rrq),
    .wrq               (mcu_wrq),
    .req_in            (mcu_req),
    .done              (mcu_done),
    .ready             (mcu_ready),
    .pend_rd           (mcu_pend_rd),
    .pend_wr           (mcu_pend_wr),
    .req_held          (mcu_held)
  );

  rom_request_slot #(.payload_t(wide_req_t)) u_dma_slot (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .rrq               (dma_rrq),
    .wrq               (dma_wrq),
    .req_in            (dma_req),
    .done              (dma_done),
    .ready             (dma_ready),
    .pend_rd           (dma_pend_rd),
    .pend_wr           (dma_pend_wr),
    .req_held          (dma_held)
  );

  ////////////////////////////////////////
  // sequencer and pins
  ////////////////////////////////////////

  rom_sequencer u_sequencer (
    .CLK2              (CLK2),
    .SNES_reset_strobe (SNES_reset_strobe),
    .free_slot         (free_slot),
    .ctx_pend_wr       (ctx_pend_wr),
    .mcu_pend_rd       (mcu_pend_rd),
    .mcu_pend_wr       (mcu_pend_wr),
    .dma_pend_rd       (dma_pend_rd),
    .dma_pend_wr       (dma_pend_wr),
    .rom_rdata         (rom_rdata),
    .rd_addr0          (rd_addr0),
    .grant             (grant),
    .writing           (writing),
    .ctx_done          (ctx_done),
    .mcu_done          (mcu_done),
    .dma_done          (dma_done),
    .mcu_rdata         (mcu_rdata),
    .dma_rdata         (dma_rdata)
  );

  rom_bus_driver u_bus_driver (
    .grant     (grant),
    .writing   (writing),
    .mcu_held  (mcu_held),
    .ctx_held  (ctx_held),
    .dma_held  (dma_held),
    .rom_addr  (rom_addr),
    .rd_addr0  (rd_addr0),
    .rom_wdata (rom_wdata),
    .rom_we_n  (rom_we_n),
    .rom_bhe_n (rom_bhe_n),
    .rom_ble_n (rom_ble_n)
  );

endmodule

// File: design/rom_bus_driver.sv
module rom_bus_driver (
  input  rom_port_pkg::req_kind_t grant,
  input  logic                    writing,
  input  rom_port_pkg::mcu_req_t  mcu_held,
  input  rom_port_pkg::wide_req_t ctx_held,
  input  rom_port_pkg::wide_req_t dma_held,
  output logic [22:0]             rom_addr,
  output logic                    rd_addr0,
  output logic [15:0]             rom_wdata,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n
);
  import rom_port_pkg::*;

  logic [rom_addr_width-1:0] sel_addr;
  logic [rom_data_width-1:0] sel_wdata;
  logic                      sel_word;
  logic                      active;

  ////////////////////////////////////////
  // payload select
  ////////////////////////////////////////

  always_comb begin
    sel_addr  = '0;
    sel_wdata = '0;
    sel_word  = 1'b0;
    case (grant)
      req_ctx_wr: begin
        sel_addr  = ctx_held.addr;
        sel_wdata = ctx_held.wdata;
        sel_word  = ctx_held.word;
      end
      req_mcu_rd, req_mcu_wr: begin
        sel_addr  = mcu_held.addr;
        sel_wdata = {mcu_held.wdata, mcu_held.wdata};  // byte on both lanes
      end
      req_dma_rd, req_dma_wr: begin
        sel_addr  = dma_held.addr;
        sel_wdata = dma_held.wdata;
        sel_word  = dma_held.word;
      end
      default: begin
        sel_addr = '0;  // bus parked
      end
    endcase
  end

  assign active = (grant != req_none);

  ////////////////////////////////////////
  // pins
  ////////////////////////////////////////

  assign rom_addr = sel_addr[rom_addr_width-1:1];
  assign rd_addr0 = sel_addr[0];

  // payload high byte rides the low lane
  assign rom_wdata = writing ? {sel_wdata[7:0], sel_wdata[15:8]} : '0;
  assign rom_we_n  = ~writing;

  // odd address is the low lane, even the high lane
  assign rom_ble_n = ~(active & (sel_addr[0] | sel_word));
  assign rom_bhe_n = ~(active & (~sel_addr[0] | sel_word));

endmodule

// File: design/rom_port_pkg.sv
package rom_port_pkg;

  ////////////////////////////////////////
  // ROM port geometry and timing
  ////////////////////////////////////////

  localparam int rom_addr_width  = 24;  // byte address
  localparam int rom_data_width  = 16;
  localparam int rom_delay_width = 4;

  // counter load, access holds for this plus one cycles
  localparam logic [rom_delay_width-1:0] rom_cycle_len = 4'd7;

  // each end state sits one bit above its address state
  typedef enum logic [10:0] {
    st_idle        = 11'b000_0000_0001,
    st_ctx_wr_addr = 11'b000_0000_0010,
    st_ctx_wr_end  = 11'b000_0000_0100,
    st_mcu_rd_addr = 11'b000_0000_1000,
    st_mcu_rd_end  = 11'b000_0001_0000,
    st_mcu_wr_addr = 11'b000_0010_0000,
    st_mcu_wr_end  = 11'b000_0100_0000,
    st_dma_rd_addr = 11'b000_1000_0000,
    st_dma_rd_end  = 11'b001_0000_0000,
    st_dma_wr_addr = 11'b010_0000_0000,
    st_dma_wr_end  = 11'b100_0000_0000
  } rom_state_t;

  // owner of the bus right now
  typedef enum logic [2:0] {
    req_none,
    req_ctx_wr,
    req_mcu_rd,
    req_mcu_wr,
    req_dma_rd,
    req_dma_wr
  } req_kind_t;

  typedef struct packed {
    logic [rom_addr_width-1:0] addr;
    logic [7:0]                wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [rom_addr_width-1:0] addr;
    logic [rom_data_width-1:0] wdata;
    logic                      word;   // both lanes
  } wide_req_t;

endpackage

// File: design/rom_request_slot.sv
module rom_request_slot #(
  parameter type payload_t = logic
) (
  input  logic     CLK2,
  input  logic     SNES_reset_strobe,
  input  logic     rrq,
  input  logic     wrq,
  input  payload_t req_in,
  input  logic     done,
  output logic     ready,
  output logic     pend_rd,
  output logic     pend_wr,
  output payload_t req_held
);

  logic accept;

  // requests only count while the slot is free
  assign accept = ready & (rrq | wrq);

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      ready   <= 1'b1;
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
    end else if (accept) begin
      ready   <= 1'b0;
      pend_rd <= rrq;         // read wins over a same-cycle write
      pend_wr <= ~rrq & wrq;
    end else if (done) begin
      ready   <= 1'b1;
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
    end
  end

  // address and data stay put until the access ends
  always_ff @(posedge CLK2) begin
    if (accept) begin
      req_held <= req_in;
    end
  end

  // requester must wait for its credit
  a_no_req_while_busy: assert property (
    @(posedge CLK2) disable iff (SNES_reset_strobe)
      (rrq | wrq) |-> ready
  ) else $error("request while slot busy");

endmodule

// File: design/rom_sequencer.sv
module rom_sequencer (
  input  logic                   CLK2,
  input  logic                   SNES_reset_strobe,
  input  logic                   free_slot,
  input  logic                   ctx_pend_wr,
  input  logic                   mcu_pend_rd,
  input  logic                   mcu_pend_wr,
  input  logic                   dma_pend_rd,
  input  logic                   dma_pend_wr,
  input  logic [15:0]            rom_rdata,
  input  logic                   rd_addr0,
  output rom_port_pkg::req_kind_t grant,
  output logic                   writing,
  output logic                   ctx_done,
  output logic                   mcu_done,
  output logic                   dma_done,
  output logic [7:0]             mcu_rdata,
  output logic [15:0]            dma_rdata
);
  import rom_port_pkg::*;

  rom_state_t                 state;
  logic [rom_delay_width-1:0] delay;

  ////////////////////////////////////////
  // access FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state <= st_idle;
      delay <= '0;
    end else begin
      case (state)
        st_idle: begin
          delay <= rom_cycle_len;
          if (free_slot) begin
            // fixed priority, one grant per slot
            if (ctx_pend_wr) begin
              state <= st_ctx_wr_addr;
            end else if (mcu_pend_rd) begin
              state <= st_mcu_rd_addr;
            end else if (mcu_pend_wr) begin
              state <= st_mcu_wr_addr;
            end else if (dma_pend_rd) begin
              state <= st_dma_rd_addr;
            end else if (dma_pend_wr) begin
              state <= st_dma_wr_addr;
            end
          end
        end
        st_ctx_wr_addr, st_mcu_rd_addr, st_mcu_wr_addr,
        st_dma_rd_addr, st_dma_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= rom_state_t'({state[9:0], 1'b0});  // to matching end
          end
        end
        default: begin
          state <= st_idle;  // end states last one cycle
        end
      endcase
    end
  end

  // bus owner for the driver, address held through the end state
  always_comb begin
    case (state)
      st_ctx_wr_addr, st_ctx_wr_end: grant = req_ctx_wr;
      st_mcu_rd_addr, st_mcu_rd_end: grant = req_mcu_rd;
      st_mcu_wr_addr, st_mcu_wr_end: grant = req_mcu_wr;
      st_dma_rd_addr, st_dma_rd_end: grant = req_dma_rd;
      st_dma_wr_addr, st_dma_wr_end: grant = req_dma_wr;
      default:                       grant = req_none;
    endcase
  end

  assign writing = (state == st_ctx_wr_addr) | (state == st_mcu_wr_addr) |
                   (state == st_dma_wr_addr);

  assign ctx_done = (state == st_ctx_wr_end);
  assign mcu_done = (state == st_mcu_rd_end) | (state == st_mcu_wr_end);
  assign dma_done = (state == st_dma_rd_end) | (state == st_dma_wr_end);

  ////////////////////////////////////////
  // read capture
  ////////////////////////////////////////

  // sampled every address cycle, last one wins
  always_ff @(posedge CLK2) begin
    if (state == st_mcu_rd_addr) begin
      mcu_rdata <= rd_addr0 ? rom_rdata[7:0] : rom_rdata[15:8];
    end
    if (state == st_dma_rd_addr) begin
      // even address comes back byte swapped
      dma_rdata <= rd_addr0 ? rom_rdata : {rom_rdata[7:0], rom_rdata[15:8]};
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_state_onehot: assert property (
    @(posedge CLK2) disable iff (SNES_reset_strobe) $onehot(state)
  ) else $error("sequencer state not one-hot");

  property p_enter_with_pend(rom_state_t addr_st, logic pend);
    @(posedge CLK2) disable iff (SNES_reset_strobe)
      (state == st_idle) ##1 (state == addr_st) |-> $past(pend);
  endproperty

  a_ctx_wr_pend: assert property (p_enter_with_pend(st_ctx_wr_addr, ctx_pend_wr));
  a_mcu_rd_pend: assert property (p_enter_with_pend(st_mcu_rd_addr, mcu_pend_rd));
  a_mcu_wr_pend: assert property (p_enter_with_pend(st_mcu_wr_addr, mcu_pend_wr));
  a_dma_rd_pend: assert property (p_enter_with_pend(st_dma_rd_addr, dma_pend_rd));
  a_dma_wr_pend: assert property (p_enter_with_pend(st_dma_wr_addr, dma_pend_wr));

endmodule

// File: design/snes_cycle_tracker.sv
module snes_cycle_tracker (
  input  logic CLK2,
  input  logic SNES_reset_strobe,
  input  logic snes_cpu_clk,
  input  logic snes_rom_hit,
  output logic cycle_start,
  output logic free_slot
);
  import snes_timing_pkg::*;

  logic [cpu_clk_hist_len-1:0] cpu_clk_hist;  // newest sample in bit 0
  logic                        cycle_end;
  logic                        free_strobe;

  ////////////////////////////////////////
  // CPU clock history
  ////////////////////////////////////////

  // raw clock is async to CLK2, bit 0 is the first sync stage
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      cpu_clk_hist <= '0;
    end else begin
      cpu_clk_hist <= {cpu_clk_hist[cpu_clk_hist_len-2:0], snes_cpu_clk};
    end
  end

  // bit 0 is skipped, it may still be metastable
  assign cycle_start = (cpu_clk_hist[cycle_pattern_len:1] == cycle_start_pattern);
  assign cycle_end   = (cpu_clk_hist[cycle_pattern_len:1] == cycle_end_pattern);

  ////////////////////////////////////////
  // free slots
  ////////////////////////////////////////

  // cycle not touching ROM leaves the bus idle right after its start
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~snes_rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

endmodule

// File: design/snes_timing_pkg.sv
package snes_timing_pkg;

  ////////////////////////////////////////
  // CPU clock sampling
  ////////////////////////////////////////

  // depth of the shift register fed by the raw CPU clock
  localparam int cpu_clk_hist_len = 8;

  // edge patterns are matched on bits [cycle_pattern_len:1],
  // so a strobe fires two CLK2 edges after the CPU clock moved
  localparam int cycle_pattern_len = 6;

  // five low samples, then high
  localparam logic [cycle_pattern_len-1:0] cycle_start_pattern = 6'b000001;

  // five high samples, then low
  localparam logic [cycle_pattern_len-1:0] cycle_end_pattern = 6'b111110;

endpackage

// File: filelist.f
design/snes_timing_pkg.sv
design/rom_port_pkg.sv
design/snes_cycle_tracker.sv
design/rom_request_slot.sv
design/rom_sequencer.sv
design/rom_bus_driver.sv
design/cart_rom_arbiter.sv
tests/psram_model.sv
tests/cart_rom_arbiter_tb.sv

// File: tests/cart_rom_arbiter_tb.sv
module cart_rom_arbiter_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rom_port_pkg::*;

  localparam int who_ctx = 0;
  localparam int who_mcu = 1;
  localparam int who_dma = 2;
  localparam int ready_timeout = 500;

  logic        CLK2 = 1'b0;
  logic        SNES_reset_strobe;
  logic        snes_cpu_clk;
  logic        snes_rom_hit;
  logic        ctx_wrq;
  wide_req_t   ctx_req;
  logic        ctx_ready;
  logic        mcu_rrq;
  logic        mcu_wrq;
  mcu_req_t    mcu_req;
  logic        mcu_ready;
  logic [7:0]  mcu_rdata;
  logic        dma_rrq;
  logic        dma_wrq;
  wide_req_t   dma_req;
  logic        dma_ready;
  logic [15:0] dma_rdata;
  logic [22:0] rom_addr;
  logic [15:0] rom_wdata;
  logic [15:0] rom_rdata;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  logic        wr_end;
  logic [22:0] wr_addr;
  logic [7:0]  wr_len;

  logic [31:0] data_lfsr = 32'h7cde;
  logic [31:0] hit_lfsr  = 32'h7cde;
  logic [7:0]  shadow [0:2047];     // expected byte per byte address
  logic [7:0]  mcu_exp [$];
  logic [15:0] dma_exp [$];
  logic [22:0] wlog [$];            // word address of each finished write
  logic        mcu_busy = 1'b0;
  logic        dma_busy = 1'b0;
  logic [2:0]  wr_busy = 3'b000;    // requester has a write in flight
  int          writes_freed = 0;
  int          cpu_cnt = 0;
  int          writes_issued = 0;
  int          n_checks = 0;
  int          n_errors = 0;

  cart_rom_arbiter u_dut (.*);

  psram_model u_model (
    .CLK2      (CLK2),
    .rom_addr  (rom_addr),
    .rom_wdata (rom_wdata),
    .rom_we_n  (rom_we_n),
    .rom_bhe_n (rom_bhe_n),
    .rom_ble_n (rom_ble_n),
    .rom_rdata (rom_rdata),
    .wr_end    (wr_end),
    .wr_addr   (wr_addr),
    .wr_len    (wr_len)
  );

  always #2 CLK2 = ~CLK2;

  ////////////////////////////////////////
  // random bits and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[30:0], data_lfsr[0]};
    end
  endtask

  // memory contents before any write, word w covers bytes 2w and 2w+1
  function automatic logic [15:0] word_fill(input int w);
    logic [31:0] p;
    p = w * 32'h9e37;
    word_fill = p[15:0] ^ 16'h3c5a;
  endfunction

  // low lane holds the odd byte, high lane the even byte
  function automatic logic [15:0] expect_read(input logic [23:0] addr);
    logic [10:0] a;
    a = addr[10:0];
    if (a[0]) expect_read = {shadow[a - 1], shadow[a]};
    else      expect_read = {shadow[a + 1], shadow[a]};  // even reads come back swapped
  endfunction

  task automatic apply_write(input logic [23:0] addr, input logic [15:0] data,
                             input logic word);
    logic [10:0] a;
    a = addr[10:0];
    if (word) begin
      shadow[a & 11'h7fe] = data[7:0];
      shadow[a | 11'h001] = data[15:8];
    end else begin
      shadow[a] = a[0] ? data[15:8] : data[7:0];
    end
  endtask

  initial begin
    logic [15:0] f;
    for (int w = 0; w < 1024; w++) begin
      f = word_fill(w);
      shadow[2*w]   = f[15:8];
      shadow[2*w+1] = f[7:0];
    end
  end

  ////////////////////////////////////////
  // checks and end of run
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_run();
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  function automatic logic ready_of(input int who);
    case (who)
      who_ctx: ready_of = ctx_ready;
      who_mcu: ready_of = mcu_ready;
      default: ready_of = dma_ready;
    endcase
  endfunction

  // call on a falling edge
  task automatic wait_ready(input int who);
    int t;
    t = 0;
    while (!ready_of(who) && t < ready_timeout) begin
      @(negedge CLK2);
      t++;
    end
    if (!ready_of(who)) begin
      n_errors++;
      $display("requester %0d never became ready again", who);
      end_run();
    end
  endtask

  task automatic wait_log(input int n);
    int t;
    t = 0;
    while (wlog.size() < n && t < 200) begin
      @(negedge CLK2);
      t++;
    end
    if (wlog.size() != n) begin
      n_errors++;
      $display("model saw %0d writes but %0d were issued", wlog.size(), n);
      end_run();
    end
  endtask

  task automatic wait_reads_done();
    int t;
    t = 0;
    while ((mcu_exp.size() != 0 || dma_exp.size() != 0) && t < 200) begin
      @(negedge CLK2);
      t++;
    end
    if (mcu_exp.size() != 0 || dma_exp.size() != 0) begin
      n_errors++;
      $display("some reads never completed");
      end_run();
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  always @(negedge CLK2) begin
    cpu_cnt++;
    if (cpu_cnt == 12) begin
      snes_cpu_clk = ~snes_cpu_clk;
      cpu_cnt = 0;
    end
    hit_lfsr = lfsr_next(hit_lfsr);
    snes_rom_hit = hit_lfsr[0];
  end

  // one access from one requester, holds until its ready allows it
  task automatic issue(input int who, input logic rd, input logic [23:0] addr,
                       input logic [15:0] data, input logic word);
    logic [15:0] e;
    @(negedge CLK2);
    wait_ready(who);
    e = expect_read(addr);
    case (who)
      who_ctx: begin
        ctx_wrq = 1'b1;
        ctx_req.addr = addr;
        ctx_req.wdata = data;
        ctx_req.word = word;
      end
      who_mcu: begin
        mcu_rrq = rd;
        mcu_wrq = ~rd;
        mcu_req.addr = addr;
        mcu_req.wdata = data[7:0];
      end
      default: begin
        dma_rrq = rd;
        dma_wrq = ~rd;
        dma_req.addr = addr;
        dma_req.wdata = data;
        dma_req.word = word;
      end
    endcase
    if (rd && who == who_mcu) mcu_exp.push_back(e[7:0]);
    else if (rd) dma_exp.push_back(e);
    else if (who == who_mcu) apply_write(addr, {data[7:0], data[7:0]}, 1'b0);
    else apply_write(addr, data, word);
    if (!rd) writes_issued++;
    @(negedge CLK2);
    case (who)
      who_ctx: ctx_wrq = 1'b0;
      who_mcu: {mcu_rrq, mcu_wrq} = 2'b00;
      default: {dma_rrq, dma_wrq} = 2'b00;
    endcase
    check_val($sformatf("ready of requester %0d", who), ready_of(who), 1'b0);
  endtask

  ////////////////////////////////////////
  // comparing process
  ////////////////////////////////////////

  always @(posedge CLK2) begin
    logic [15:0] e;
    if (wr_end) begin
      wlog.push_back(wr_addr);
      check_val("wr_len", wr_len, 8);  // rom_we_n low for the whole access
    end
    // a write's ready may only come back once the model has seen it end
    for (int w = 0; w < 3; w++) begin
      if (wr_busy[w] && ready_of(w)) begin
        wr_busy[w] = 1'b0;
        writes_freed++;
        check_val("wlog size", wlog.size(), writes_freed);
      end
    end
    if (mcu_busy && mcu_ready) begin
      e[7:0] = mcu_exp.pop_front();
      check_val("mcu_rdata", mcu_rdata, e[7:0]);
      mcu_busy = 1'b0;
    end
    if (dma_busy && dma_ready) begin
      e = dma_exp.pop_front();
      check_val("dma_rdata", dma_rdata, e);
      dma_busy = 1'b0;
    end
    if (!SNES_reset_strobe && mcu_ready && mcu_rrq) mcu_busy = 1'b1;
    if (!SNES_reset_strobe && dma_ready && dma_rrq) dma_busy = 1'b1;
    if (!SNES_reset_strobe && ctx_ready && ctx_wrq) wr_busy[who_ctx] = 1'b1;
    if (!SNES_reset_strobe && mcu_ready && mcu_wrq) wr_busy[who_mcu] = 1'b1;
    if (!SNES_reset_strobe && dma_ready && dma_wrq) wr_busy[who_dma] = 1'b1;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [23:0] a [0:11];
    logic [15:0] d [0:11];
    int base;
    SNES_reset_strobe = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_rom_hit = 1'b0;
    ctx_wrq = 1'b0;
    ctx_req = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_req = '0;
    dma_rrq = 1'b0;
    dma_wrq = 1'b0;
    dma_req = '0;
    repeat (3) @(negedge CLK2);
    SNES_reset_strobe = 1'b0;

    // idle bus after reset
    check_val("ctx_ready", ctx_ready, 1'b1);
    check_val("mcu_ready", mcu_ready, 1'b1);
    check_val("dma_ready", dma_ready, 1'b1);
    check_val("rom_we_n", rom_we_n, 1'b1);
    check_val("rom_bhe_n", rom_bhe_n, 1'b1);
    check_val("rom_ble_n", rom_ble_n, 1'b1);
    repeat (20) @(negedge CLK2);
    check_val("write log size", wlog.size(), 0);

    // mcu byte write, then the byte and its neighbour
    for (int i = 0; i < 6; i++) begin
      rand_bits(16, r);
      issue(who_mcu, 1'b0, 24'h100 + r[15:8], {8'h00, r[7:0]}, 1'b0);
      issue(who_mcu, 1'b1, 24'h100 + r[15:8], '0, 1'b0);
      issue(who_mcu, 1'b1, (24'h100 + r[15:8]) ^ 24'h1, '0, 1'b0);
    end

    // word writes from dma and ctx, read back by dma at both parities
    for (int i = 0; i < 4; i++) begin
      rand_bits(8, r);
      a[0] = 24'h200 + {r[7:1], i[0]};  // read parity alternates
      rand_bits(8, r);
      a[1] = 24'h000 + {r[7:1], i[0]};
      rand_bits(32, r);
      issue(who_dma, 1'b0, a[0], r[15:0], 1'b1);
      issue(who_ctx, 1'b0, a[1], r[31:16], 1'b1);
      issue(who_dma, 1'b1, a[0], '0, 1'b1);
      issue(who_dma, 1'b1, a[1] ^ 24'h1, '0, 1'b1);
    end

    // same-cycle writes land in priority order
    wait_log(writes_issued);
    wait_ready(who_ctx);
    wait_ready(who_mcu);
    wait_ready(who_dma);
    base = wlog.size();
    for (int i = 0; i < 12; i++) begin
      rand_bits(24, r);
      a[i] = (24'h100 * (i % 3)) + r[7:0];  // one window per requester
      d[i] = r[23:8];
    end
    fork
      issue(who_ctx, 1'b0, a[0], d[0], 1'b1);
      issue(who_mcu, 1'b0, a[1], d[1], 1'b0);
      issue(who_dma, 1'b0, a[2], d[2], 1'b1);
    join
    wait_log(writes_issued);
    check_val("first write addr", wlog[base], a[0] >> 1);
    check_val("second write addr", wlog[base+1], a[1] >> 1);
    check_val("third write addr", wlog[base+2], a[2] >> 1);

    // all three stream writes back to back under back-pressure
    fork
      for (int k = 0; k < 12; k += 3) issue(who_ctx, 1'b0, a[k], d[k], 1'b1);
      for (int k = 1; k < 12; k += 3) issue(who_mcu, 1'b0, a[k], d[k], 1'b0);
      for (int k = 2; k < 12; k += 3) issue(who_dma, 1'b0, a[k], d[k], 1'b1);
    join
    wait_log(writes_issued);
    for (int i = 0; i < 12; i++) begin
      issue(who_mcu, 1'b1, a[i], '0, 1'b0);
      issue(who_dma, 1'b1, a[i], '0, 1'b1);
    end

    @(negedge CLK2);
    wait_ready(who_mcu);
    wait_ready(who_dma);
    wait_reads_done();
    end_run();
  end

endmodule

// File: tests/psram_model.sv
module psram_model (
  input  logic        CLK2,
  input  logic [22:0] rom_addr,
  input  logic [15:0] rom_wdata,
  input  logic        rom_we_n,
  input  logic        rom_bhe_n,
  input  logic        rom_ble_n,
  output logic [15:0] rom_rdata,
  output logic        wr_end,   // one cycle after a write run ends
  output logic [22:0] wr_addr,
  output logic [7:0]  wr_len    // cycles of rom_we_n low
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int depth = 1024;

  logic [15:0] mem [0:depth-1];
  logic [7:0]  run_len;

  // every word differs, built from the whole word index
  function automatic logic [15:0] fill_word(input int w);
    logic [31:0] p;
    p = w * 32'h9e37;
    fill_word = p[15:0] ^ 16'h3c5a;
  endfunction

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = fill_word(i);
    end
    run_len = '0;
    wr_end  = 1'b0;
    wr_addr = '0;
    wr_len  = '0;
  end

  assign rom_rdata = mem[rom_addr[9:0]];

  always @(posedge CLK2) begin
    wr_end <= 1'b0;
    if (!rom_we_n) begin
      if (!rom_bhe_n) mem[rom_addr[9:0]][15:8] <= rom_wdata[15:8];
      if (!rom_ble_n) mem[rom_addr[9:0]][7:0]  <= rom_wdata[7:0];
      run_len <= run_len + 1'b1;
      wr_addr <= rom_addr;
    end else if (run_len != 0) begin
      wr_len  <= run_len;  // report the finished run
      wr_end  <= 1'b1;
      run_len <= '0;
    end
  end

endmodule
